/* Bender.yml */
package:
  name: mips_fetch

sources:
  - verilog/mipsPkg.sv
  - verilog/programLoader.sv
  - verilog/instructionMemory.sv
  - verilog/fetchUnit.sv
  - verilog/fetchStage.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/fetchChecker.sv
      - testbench/fetchTb.sv

/* filelist.f */
verilog/mipsPkg.sv
verilog/programLoader.sv
verilog/instructionMemory.sv
verilog/fetchUnit.sv
verilog/fetchStage.sv
testbench/clockGen.sv
testbench/fetchChecker.sv
testbench/fetchTb.sv

/* testbench/clockGen.sv */
`timescale 1ns/10ps

// Free running 100 ns clock and a reset held over two rising edges
module clockGen (
    output logic o_clock,
    output logic o_reset
);

    initial begin
        o_clock = 1'b0;
        forever #50 o_clock = ~o_clock;  // Half period
    end

    initial begin
        o_reset = 1'b1;
        repeat (2) @(posedge o_clock);
        @(negedge o_clock);  // Released on a falling edge like every other input
        o_reset = 1'b0;
    end

endmodule

/* testbench/fetchChecker.sv */
`timescale 1ns/10ps

// Scoreboard that reads the fetch stage IF/ID outputs mid cycle
module fetchChecker (
    input logic                          i_clock,
    input logic                          i_run,
    input logic                          i_stall,
    input logic                          i_branchTaken,
    input logic [mipsPkg::WORD_BITS-1:0] i_pc,
    input logic [mipsPkg::WORD_BITS-1:0] i_instruction,
    input logic                          i_valid,
    input logic                          i_branch,
    input logic [mipsPkg::WORD_BITS-1:0] i_targetOffset
);

    // Expected IF/ID slots in fetch order
    logic [mipsPkg::WORD_BITS-1:0] expPc[$];
    logic [mipsPkg::WORD_BITS-1:0] expWord[$];
    logic                          expBranch[$];
    logic [mipsPkg::WORD_BITS-1:0] expOffset[$];

    int   errorCount  = 0;  // Whole run
    int   testErrors  = 0;  // Current test only
    int   testsRun    = 0;
    int   testsFailed = 0;
    logic lastValid   = 1'b0;
    logic takenSeen   = 1'b0;  // Decode strobe seen at the last rising edge
    logic refillDue   = 1'b0;  // Branch target registered at the last rising edge
    logic [mipsPkg::WORD_BITS-1:0] lastPc;

    task automatic expectSlot(input logic [31:0] pc, input logic [31:0] word,
                              input logic branch, input logic [31:0] offset);
        expPc.push_back(pc);
        expWord.push_back(word);
        expBranch.push_back(branch);
        expOffset.push_back(offset);
    endtask

    task automatic flagProblem(input string message);
        $display("ERROR %0t ns: %s", $time, message);
        errorCount++;
        testErrors++;
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %0t ns %s expected %h got %h", $time, name, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic expectDrained();
        if (expPc.size() != 0) flagProblem($sformatf("%0d expected slots never showed up",
                                                     expPc.size()));
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (testErrors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    task automatic summarize();
        $display("summary: %0d tests, %0d with errors, %0d errors in total",
                 testsRun, testsFailed, errorCount);
    endtask

    always @(posedge i_clock) begin
        refillDue <= takenSeen && i_run && !i_stall;  // Flush slot ends, target fetch free to go
        takenSeen <= i_branchTaken;                   // Stable since the falling edge
    end

    // Every new valid slot is matched against the head of the queue
    always @(negedge i_clock) begin
        if (takenSeen) checkValue("o_valid (flushed slot)", i_valid, 0);
        if (refillDue) checkValue("o_valid (branch target slot)", i_valid, 1);
        if (i_valid === 1'b1 && (!lastValid || i_pc !== lastPc)) begin
            if (expPc.size() == 0) begin
                flagProblem($sformatf("valid slot at pc %h with nothing left to expect", i_pc));
            end else begin
                checkValue("o_pc", i_pc, expPc.pop_front());
                checkValue("o_instruction", i_instruction, expWord.pop_front());
                checkValue("o_branch", i_branch, expBranch.pop_front());
                checkValue("o_targetOffset", i_targetOffset, expOffset.pop_front());
            end
        end
        lastValid = (i_valid === 1'b1);  // A stalled slot repeats with the same PC
        lastPc    = i_pc;
    end

endmodule

/* testbench/fetchTb.sv */
`timescale 1ns/10ps

// Testbench top that takes the program and expected slots from the golden image
module fetchTb;

    // Golden image layout in array entries
    localparam int COUNT_BASE = 'h00;  // Byte count, slot count, branch count
    localparam int BYTE_BASE  = 'h10;
    localparam int SLOT_BASE  = 'h40;  // Four entries per slot
    localparam int TAKEN_BASE = 'h80;
    localparam int WAIT_LIMIT = 40;    // Cycles for a flag to settle
    localparam int RUN_LIMIT  = 300;

    logic        i_clock, i_reset;
    logic [7:0]  i_byte;
    logic        i_byteValid, i_clear, i_run, i_stall, i_branchTaken;
    logic [31:0] o_pc, o_instruction, o_targetOffset;
    logic        o_valid, o_branch, o_fullMem, o_emptyMem;
    logic [31:0] golden [0:255];
    int unsigned lcgState = 43;  // Stall pattern seed
    int          n, cycles, slotCount, branchIndex;
    logic        prevValid;
    logic [31:0] prevPc;

    clockGen clocks (.o_clock(i_clock), .o_reset(i_reset));

    fetchStage i_dut (.*);

    fetchChecker monitor (
        .i_clock        (i_clock),
        .i_run          (i_run),
        .i_stall        (i_stall),
        .i_branchTaken  (i_branchTaken),
        .i_pc           (o_pc),
        .i_instruction  (o_instruction),
        .i_valid        (o_valid),
        .i_branch       (o_branch),
        .i_targetOffset (o_targetOffset)
    );

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;  // Low bits of an LCG cycle too quickly
    endfunction

    // Never zero and different at every address
    function automatic logic [31:0] fillWord(input logic [8:0] addr);
        return {addr, 7'h35, ~addr, 7'h4B};
    endfunction

    task automatic sendByte(input logic [7:0] value);
        i_byte      = value;
        i_byteValid = 1'b1;
        @(negedge i_clock);
        i_byteValid = 1'b0;
    endtask

    task automatic sendWord(input logic [31:0] word);
        int k;
        for (k = 0; k < 4; k++) sendByte(word[8*k +: 8]);  // LSB first
    endtask

    task automatic abortRun(input string reason);
        $display("ERROR %0t ns: timeout, %s", $time, reason);
        monitor.summarize();
        $display("test failed");
        $finish;
    endtask

    initial begin
        i_byte        = '0;
        i_byteValid   = 1'b0;
        i_clear       = 1'b0;
        i_run         = 1'b0;
        i_stall       = 1'b0;
        i_branchTaken = 1'b0;
        $readmemh("testbench/fetch_golden.txt", golden);
        for (n = 0; n < golden[COUNT_BASE+1]; n++) begin
            monitor.expectSlot(golden[SLOT_BASE+4*n], golden[SLOT_BASE+4*n+1],
                               golden[SLOT_BASE+4*n+2][0], golden[SLOT_BASE+4*n+3]);
        end

        cycles = 0;
        do begin
            @(posedge i_clock);
            cycles++;
        end while (i_reset && cycles < WAIT_LIMIT);
        if (i_reset) abortRun("reset was never released");
        @(negedge i_clock);
        monitor.checkValue("o_emptyMem", o_emptyMem, 1);
        monitor.checkValue("o_fullMem", o_fullMem, 0);
        monitor.checkValue("o_valid", o_valid, 0);
        monitor.endTest("reset state");

        // Fill every word, then push one more into the full store
        for (n = 0; n < mipsPkg::MEM_DEPTH; n++) sendWord(fillWord(n));
        cycles = 0;
        while (!o_fullMem && cycles < WAIT_LIMIT) begin
            @(negedge i_clock);
            cycles++;
        end
        if (!o_fullMem) abortRun("memory never reported full after 512 words");
        sendWord(fillWord(9'd0));
        repeat (3) @(negedge i_clock);
        monitor.checkValue("o_fullMem", o_fullMem, 1);
        monitor.checkValue("o_emptyMem", o_emptyMem, 0);
        monitor.endTest("full memory");

        i_clear = 1'b1;
        @(negedge i_clock);
        i_clear = 1'b0;
        monitor.checkValue("o_emptyMem", o_emptyMem, 1);
        monitor.checkValue("o_fullMem", o_fullMem, 0);
        monitor.endTest("clear");

        // Old fill words above the program must now read as NOP
        for (n = 0; n < golden[COUNT_BASE]; n++) begin
            if (n == 4) monitor.checkValue("o_emptyMem", o_emptyMem, 1);  // Strobe just issued
            if (n == 5) monitor.checkValue("o_emptyMem", o_emptyMem, 0);  // Pointer moved
            sendByte(golden[BYTE_BASE+n][7:0]);
        end
        repeat (2) @(negedge i_clock);  // Last word lands in the array
        monitor.checkValue("o_emptyMem", o_emptyMem, 0);
        monitor.endTest("program load");

        i_run       = 1'b1;
        slotCount   = 0;
        branchIndex = 0;
        cycles      = 0;
        prevValid   = 1'b0;
        while (slotCount < golden[COUNT_BASE+1] && cycles < RUN_LIMIT) begin
            @(negedge i_clock);
            cycles++;
            i_branchTaken = 1'b0;
            if (o_valid && (!prevValid || o_pc != prevPc)) begin
                slotCount++;
                if (o_branch) begin
                    i_branchTaken = golden[TAKEN_BASE+branchIndex][0];  // Decode's verdict
                    branchIndex++;
                end
            end
            prevValid = o_valid;
            prevPc    = o_pc;
            i_stall   = (nextRandom() % 4 == 0);
        end
        i_run         = 1'b0;
        i_stall       = 1'b0;
        i_branchTaken = 1'b0;
        if (slotCount < golden[COUNT_BASE+1]) abortRun("fetch stopped delivering slots");
        if (branchIndex != golden[COUNT_BASE+2]) begin
            monitor.flagProblem($sformatf("%0d branch slots fetched but %0d decisions scheduled",
                                          branchIndex, golden[COUNT_BASE+2]));
        end
        repeat (2) @(negedge i_clock);
        monitor.expectDrained();
        monitor.endTest("fetch, predecode and branch");

        monitor.summarize();
        if (monitor.errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* testbench/fetch_golden.txt */
// @00 counts: program bytes, expected slots, branch decisions
// @10 program bytes LSB first, @40 slots as pc word branch offset, @80 taken per branch slot
@00
20 0B 04
@10
01 00 01 20 02 00 00 10
02 00 02 20 03 00 03 20
FD FF 20 14 04 00 04 20
F0 FF 00 10 00 00 05 8C
@40
00000000 20010001 0 00000000
00000004 10000002 1 00000002
00000010 1420FFFD 1 FFFFFFFD
00000008 20020002 0 00000000
0000000C 20030003 0 00000000
00000010 1420FFFD 1 FFFFFFFD
00000014 20040004 0 00000000
00000018 1000FFF0 1 FFFFFFF0
0000001C 8C050000 0 00000000
00000020 00000000 0 00000000
00000024 00000000 0 00000000
@80
1 1 0 0

/* verilog/fetchStage.sv */
`timescale 1ns/10ps

// Fetch stage top: debug loader, instruction store and fetch unit
module fetchStage (
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic [mipsPkg::BYTE_BITS-1:0] i_byte,
    input  logic                          i_byteValid,
    input  logic                          i_clear,
    input  logic                          i_run,
    input  logic                          i_stall,
    input  logic                          i_branchTaken,
    output logic [mipsPkg::WORD_BITS-1:0] o_pc,
    output logic [mipsPkg::WORD_BITS-1:0] o_instruction,
    output logic                          o_valid,
    output logic                          o_branch,
    output logic [mipsPkg::WORD_BITS-1:0] o_targetOffset,
    output logic                          o_fullMem,
    output logic                          o_emptyMem
);

    logic [mipsPkg::WORD_BITS-1:0] loadWord;       // Packed word from the loader
    logic                          loadWrite;
    logic [mipsPkg::ADDR_BITS-1:0] fetchAddr;      // PC word address
    logic [mipsPkg::WORD_BITS-1:0] memInstruction; // Combinational read data
    logic                          memBranch;
    logic [mipsPkg::WORD_BITS-1:0] memTargetOffset;

    programLoader loader (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_clear     (i_clear),
        .i_run       (i_run),
        .i_byte      (i_byte),
        .i_byteValid (i_byteValid),
        .o_word      (loadWord),
        .o_wordWrite (loadWrite)
    );

    instructionMemory memory (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_clear        (i_clear),
        .i_word         (loadWord),
        .i_wordWrite    (loadWrite),
        .i_readAddr     (fetchAddr),
        .o_instruction  (memInstruction),
        .o_branch       (memBranch),
        .o_targetOffset (memTargetOffset),
        .o_fullMem      (o_fullMem),
        .o_emptyMem     (o_emptyMem)
    );

    fetchUnit fetch (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_run          (i_run),
        .i_stall        (i_stall),
        .i_branchTaken  (i_branchTaken),
        .i_instruction  (memInstruction),
        .i_branch       (memBranch),
        .i_targetOffset (memTargetOffset),
        .o_readAddr     (fetchAddr),
        .o_pc           (o_pc),
        .o_instruction  (o_instruction),
        .o_valid        (o_valid),
        .o_branch       (o_branch),
        .o_targetOffset (o_targetOffset)
    );

endmodule

/* verilog/fetchUnit.sv */
`timescale 1ns/10ps

// Program counter and IF/ID pipeline register
module fetchUnit (
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_run,
    input  logic                          i_stall,
    input  logic                          i_branchTaken,
    input  logic [mipsPkg::WORD_BITS-1:0] i_instruction,
    input  logic                          i_branch,
    input  logic [mipsPkg::WORD_BITS-1:0] i_targetOffset,
    output logic [mipsPkg::ADDR_BITS-1:0] o_readAddr,
    output logic [mipsPkg::WORD_BITS-1:0] o_pc,
    output logic [mipsPkg::WORD_BITS-1:0] o_instruction,
    output logic                          o_valid,
    output logic                          o_branch,
    output logic [mipsPkg::WORD_BITS-1:0] o_targetOffset
);

    logic [mipsPkg::WORD_BITS-1:0] pc;            // Address being fetched this cycle
    logic [mipsPkg::WORD_BITS-1:0] branchTarget;
    logic                          takeBranch;    // Redirect from decode
    logic                          advance;       // Normal sequential step

    // Byte PC to word address, drop the two alignment bits
    assign o_readAddr = pc[mipsPkg::ADDR_BITS+1:2];

    assign takeBranch = i_branchTaken && o_branch;
    assign advance    = i_run && !i_stall && !takeBranch;

    // Target from the branch held in IF/ID, offset counted in words
    assign branchTarget = o_pc + mipsPkg::PC_STEP
                        + {o_targetOffset[mipsPkg::WORD_BITS-3:0], 2'b00};

    // Program counter
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc <= mipsPkg::RESET_PC;
        end else if (takeBranch) begin
            pc <= branchTarget;  // Flush wins over a stall
        end else if (advance) begin
            pc <= pc + mipsPkg::PC_STEP;
        end
    end

    // IF/ID control bits
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid  <= 1'b0;
            o_branch <= 1'b0;
        end else if (!i_run || takeBranch) begin
            // Halted, or the slot behind a taken branch is squashed
            o_valid  <= 1'b0;
            o_branch <= 1'b0;
        end else if (!i_stall) begin
            o_valid  <= 1'b1;
            o_branch <= i_branch;
        end
    end

    // IF/ID payload, only meaningful while o_valid is high
    always_ff @(posedge i_clock) begin
        if (advance) begin
            o_pc           <= pc;            // PC that went with this word
            o_instruction  <= i_instruction;
            o_targetOffset <= i_targetOffset;
        end
    end

    // Decode only resolves a branch that is actually sitting in IF/ID
    branchOnlyOnValid: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_branchTaken |-> (o_branch && o_valid)
    );

endmodule

/* verilog/instructionMemory.sv */
`timescale 1ns/10ps

// Program store filled by the debug loader, read by the fetch unit
module instructionMemory (
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_clear,
    input  logic [mipsPkg::WORD_BITS-1:0] i_word,
    input  logic                          i_wordWrite,
    input  logic [mipsPkg::ADDR_BITS-1:0] i_readAddr,
    output logic [mipsPkg::WORD_BITS-1:0] o_instruction,
    output logic                          o_branch,
    output logic [mipsPkg::WORD_BITS-1:0] o_targetOffset,
    output logic                          o_fullMem,
    output logic                          o_emptyMem
);

    logic [mipsPkg::WORD_BITS-1:0]   memory [0:mipsPkg::MEM_DEPTH-1];
    logic [mipsPkg::COUNT_BITS-1:0]  wordCount;    // Write pointer, also the number of words held
    logic                            writeEnable;
    logic                            addrLoaded;   // Read address below the pointer
    logic [mipsPkg::OPCODE_BITS-1:0] opcode;
    logic [mipsPkg::IMM_BITS-1:0]    immediate;

    assign o_fullMem   = (wordCount == mipsPkg::FULL_COUNT);
    assign o_emptyMem  = (wordCount == '0);
    assign writeEnable = i_wordWrite && !o_fullMem;  // Strobe while full is dropped

    // Write pointer
    always_ff @(posedge i_clock) begin
        if (i_reset || i_clear) begin
            wordCount <= '0;  // Old words stay in the array but read back as NOP
        end else if (writeEnable) begin
            wordCount <= wordCount + 1'b1;
        end
    end

    // Storage, appended at the pointer
    always_ff @(posedge i_clock) begin
        if (writeEnable) begin
            memory[wordCount[mipsPkg::ADDR_BITS-1:0]] <= i_word;
        end
    end

    // Anything at or past the pointer is stale
    assign addrLoaded    = ({1'b0, i_readAddr} < wordCount);
    assign o_instruction = addrLoaded ? memory[i_readAddr] : '0;

    assign opcode    = o_instruction[mipsPkg::WORD_BITS-1 -: mipsPkg::OPCODE_BITS];
    assign immediate = o_instruction[mipsPkg::IMM_BITS-1:0];

    // Branch predecode, resolved later in decode
    always_comb begin
        if (opcode == mipsPkg::OPCODE_BEQ || opcode == mipsPkg::OPCODE_BNE) begin
            o_branch       = 1'b1;
            o_targetOffset = {{(mipsPkg::WORD_BITS - mipsPkg::IMM_BITS){immediate[
                mipsPkg::IMM_BITS-1]}}, immediate};  // Sign extend, offset in words
        end else begin
            o_branch       = 1'b0;
            o_targetOffset = '0;
        end
    end

    // A write attempted while full leaves the count pinned at full
    fullWriteDropped: assert property (
        @(posedge i_clock) disable iff (i_reset || i_clear)
        (i_wordWrite && o_fullMem) |=> (wordCount == mipsPkg::FULL_COUNT)
    );

    // Pointer stays within the array plus the full marker
    pointerInRange: assert property (
        @(posedge i_clock) disable iff (i_reset)
        wordCount <= mipsPkg::FULL_COUNT
    );

endmodule

/* verilog/mipsPkg.sv */
package mipsPkg;

    // Instruction store geometry
    localparam int MEM_DEPTH  = 512;           // Words in the instruction memory
    localparam int ADDR_BITS  = 9;             // Word address width
    localparam int COUNT_BITS = ADDR_BITS + 1; // Word count has to reach MEM_DEPTH itself

    // Data widths
    localparam int WORD_BITS   = 32;  // Instruction and PC width
    localparam int BYTE_BITS   = 8;   // Debug host byte
    localparam int OPCODE_BITS = 6;   // Top field of every instruction
    localparam int IMM_BITS    = 16;  // I-type immediate

    // Count value that marks the memory as full
    localparam logic [COUNT_BITS-1:0] FULL_COUNT = COUNT_BITS'(MEM_DEPTH);

    // Conditional branches recognised by predecode
    localparam logic [OPCODE_BITS-1:0] OPCODE_BEQ = 6'd4;
    localparam logic [OPCODE_BITS-1:0] OPCODE_BNE = 6'd5;

    // Program counter
    localparam logic [WORD_BITS-1:0] RESET_PC = '0;
    localparam logic [WORD_BITS-1:0] PC_STEP  = 32'd4;  // One word per fetch

endpackage

/* verilog/programLoader.sv */
`timescale 1ns/10ps

// Collects the debug byte stream into 32-bit words for the instruction memory
module programLoader (
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_clear,
    input  logic                          i_run,
    input  logic [mipsPkg::BYTE_BITS-1:0] i_byte,
    input  logic                          i_byteValid,
    output logic [mipsPkg::WORD_BITS-1:0] o_word,
    output logic                          o_wordWrite
);

    logic [1:0] byteCount;   // Bytes already packed into the current word
    logic       acceptByte;  // Byte taken this cycle
    logic       lastByte;    // Byte that completes a word

    // Host bytes only count while the pipeline is halted
    assign acceptByte = i_byteValid && !i_run;
    assign lastByte   = acceptByte && (byteCount == 2'd3);

    // Byte counter and one-cycle write strobe
    always_ff @(posedge i_clock) begin
        if (i_reset || i_clear) begin
            byteCount   <= 2'd0;  // Restart on a word boundary
            o_wordWrite <= 1'b0;
        end else begin
            o_wordWrite <= lastByte;  // High the cycle after the fourth byte
            if (acceptByte) begin
                byteCount <= byteCount + 2'd1;  // Wraps back to zero after byte four
            end
        end
    end

    // Least significant byte arrives first
    // New byte enters at the top, older bytes move toward bit 0
    always_ff @(posedge i_clock) begin
        if (acceptByte) begin
            o_word <= {i_byte, o_word[mipsPkg::WORD_BITS-1:mipsPkg::BYTE_BITS]};
        end
    end

endmodule
